/* compile.f */
dma_cfg_pkg.sv
dma_types_pkg.sv
dma_ifs.sv
dma_reg_decode.sv
dma_page_splitter.sv
dma_copy_engine.sv
dma_completion.sv
dma_top.sv
dma_properties.sv
tb_dma.sv

/* Bender.yml */
package:
  name: dma_copy

sources:
  - dma_cfg_pkg.sv
  - dma_types_pkg.sv
  - dma_ifs.sv
  - dma_reg_decode.sv
  - dma_page_splitter.sv
  - dma_copy_engine.sv
  - dma_completion.sv
  - dma_top.sv
  - target: test
    files:
      - dma_properties.sv
      - tb_dma.sv

/* tb_dma.sv */
/*
 * Testbench for the copy DMA
 * Drives register jobs from an LFSR, models a 1024-word memory with an
 * error region and checks memory and ID registers against a model
 */
`timescale 1ns/1ps

module tb_dma;

  localparam int unsigned AW        = dma_cfg_pkg::AddrWidth;
  localparam int unsigned DW        = dma_cfg_pkg::DataWidth;
  localparam int unsigned IW        = dma_cfg_pkg::IdWidth;
  localparam int unsigned MemWords  = 1024;
  localparam int unsigned WaitLimit = 2000;
  localparam logic [AW-1:0] ErrLo   = 16'h0300;
  localparam logic [AW-1:0] ErrHi   = 16'h030f;

  logic                                 clk = 1'b0;
  logic                                 arst_n;
  logic                                 reg_we;
  logic                                 reg_re;
  logic [dma_cfg_pkg::RegAddrWidth-1:0] reg_addr;
  logic [DW-1:0]                        reg_wdata;
  logic [DW-1:0]                        reg_rdata;
  logic                                 mem_req;
  logic                                 mem_we;
  logic [AW-1:0]                        mem_addr;
  logic [DW-1:0]                        mem_wdata;
  logic [DW-1:0]                        mem_rdata = '0;
  logic                                 mem_err = 1'b0;

  logic [DW-1:0] mem   [MemWords];
  logic [DW-1:0] model [MemWords];
  logic          rd_pending = 1'b0;
  logic [AW-1:0] rd_addr = '0;
  int unsigned   write_count = 0;
  logic [31:0]   lfsr_q = 32'hcc36_c0a6;
  logic [IW-1:0] exp_next_id;
  int unsigned   checks;
  int unsigned   errors;
  int unsigned   tests;

  dma_top i_dma_top (
    .clk_i       ( clk       ),
    .arst_n_i    ( arst_n    ),
    .reg_we_i    ( reg_we    ),
    .reg_re_i    ( reg_re    ),
    .reg_addr_i  ( reg_addr  ),
    .reg_wdata_i ( reg_wdata ),
    .reg_rdata_o ( reg_rdata ),
    .mem_req_o   ( mem_req   ),
    .mem_we_o    ( mem_we    ),
    .mem_addr_o  ( mem_addr  ),
    .mem_wdata_o ( mem_wdata ),
    .mem_rdata_i ( mem_rdata ),
    .mem_err_i   ( mem_err   )
  );

  always #4 clk = ~clk;

  // Memory model samples requests at the rising edge
  always @(posedge clk) begin
    if (mem_we) begin
      mem[mem_addr[9:0]] <= mem_wdata;
      write_count        <= write_count + 1;
    end
    rd_pending <= mem_req && !mem_we;
    rd_addr    <= mem_addr;
  end

  // Read answer of the previous cycle goes out on the falling edge
  always @(negedge clk) begin
    mem_rdata <= mem[rd_addr[9:0]];
    mem_err   <= rd_pending && in_err_region(rd_addr);
  end

  function automatic logic in_err_region(input logic [AW-1:0] addr);
    return (addr >= ErrLo) && (addr <= ErrHi);
  endfunction

  // Fibonacci LFSR with taps 32 22 2 1 and one step per bit
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] value;
    logic        fb;
    value = '0;
    for (int unsigned i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      value  = {value[30:0], fb};
    end
    return value;
  endfunction

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR @ %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("Timed out after %0d register polls waiting for %s", WaitLimit, what);
    $display("Test FAILED");
    $finish;
  endtask

  task automatic reg_write(input logic [2:0] addr, input logic [31:0] data);
    @(negedge clk);
    reg_we    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(negedge clk);
    reg_we = 1'b0;
  endtask

  // Read data is registered, so it is there one falling edge later
  task automatic reg_read(input logic [2:0] addr, output logic [31:0] data);
    @(negedge clk);
    reg_re   = 1'b1;
    reg_addr = addr;
    @(negedge clk);
    reg_re = 1'b0;
    data   = reg_rdata;
  endtask

  // Launch a job and apply it to the model in issue order
  task automatic launch(input logic [AW-1:0] src, input logic [AW-1:0] dst,
                        input logic [15:0] len);
    logic [AW-1:0] s;
    logic [AW-1:0] d;
    reg_write(dma_cfg_pkg::RegSrc, 32'(src));
    reg_write(dma_cfg_pkg::RegDst, 32'(dst));
    reg_write(dma_cfg_pkg::RegLen, 32'(len));
    if (len != '0) begin
      for (int unsigned i = 0; i < len; i++) begin
        s = src + AW'(i);
        d = dst + AW'(i);
        if (!in_err_region(s)) begin
          model[d[9:0]] = model[s[9:0]];
        end
      end
      exp_next_id++;
    end
  endtask

  task automatic wait_done(input logic [IW-1:0] target);
    logic [31:0] value;
    logic        found;
    int unsigned n;
    found = 1'b0;
    n     = 0;
    while (!found && n < WaitLimit) begin
      reg_read(dma_cfg_pkg::RegDoneId, value);
      found = (value[IW-1:0] == target);
      n++;
    end
    if (!found) begin
      stop_on_timeout($sformatf("done ID %0d", target));
    end
  endtask

  task automatic wait_idle();
    logic [31:0] value;
    logic        idle;
    int unsigned n;
    idle = 1'b0;
    n    = 0;
    while (!idle && n < WaitLimit) begin
      reg_read(dma_cfg_pkg::RegStatus, value);
      idle = !value[dma_cfg_pkg::StatusBusyBit];
      n++;
    end
    if (!idle) begin
      stop_on_timeout("the busy bit to clear");
    end
  endtask

  task automatic compare_memory();
    for (int unsigned a = 0; a < MemWords; a++) begin
      check($sformatf("memory word %h", a[9:0]), mem[a], model[a]);
    end
  endtask

  task automatic end_test(input string name, input int unsigned errors_before);
    tests++;
    $display("%-34s %s", name, (errors == errors_before) ? "passed" : "failed");
  endtask

  initial begin
    logic [31:0]   value;
    logic [AW-1:0] src;
    logic [AW-1:0] dst;
    logic [15:0]   len;
    logic [IW-1:0] done_start;
    int unsigned   err_mark;
    int unsigned   writes_before;

    reg_we      = 1'b0;
    reg_re      = 1'b0;
    reg_addr    = '0;
    reg_wdata   = '0;
    arst_n      = 1'b0;
    exp_next_id = '0;
    checks      = 0;
    errors      = 0;
    tests       = 0;
    for (int unsigned a = 0; a < MemWords; a++) begin
      mem[a]   = {6'h2d, a[9:0], 6'h15, ~a[9:0]};
      model[a] = {6'h2d, a[9:0], 6'h15, ~a[9:0]};
    end
    repeat (8) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    // IDs after reset and address register read-back
    err_mark = errors;
    reg_read(dma_cfg_pkg::RegNextId, value);
    check("next ID after reset", value, '0);
    reg_read(dma_cfg_pkg::RegDoneId, value);
    check("done ID after reset", value, '0);
    src = AW'(rand_bits(16));
    dst = AW'(rand_bits(16));
    reg_write(dma_cfg_pkg::RegSrc, 32'(src));
    reg_write(dma_cfg_pkg::RegDst, 32'(dst));
    reg_read(dma_cfg_pkg::RegSrc, value);
    check("source register", value, 32'(src));
    reg_read(dma_cfg_pkg::RegDst, value);
    check("destination register", value, 32'(dst));
    end_test("reset and register read-back", err_mark);

    // One job inside a single page on both sides
    err_mark = errors;
    src = AW'(rand_bits(5) << 4) | AW'(rand_bits(3));
    dst = 16'h0200 | AW'(rand_bits(4) << 4) | AW'(rand_bits(3));
    len = 16'd1 + 16'(rand_bits(3));
    launch(src, dst, len);
    reg_read(dma_cfg_pkg::RegNextId, value);
    check("next ID after one job", value, 32'(exp_next_id));
    wait_done(exp_next_id);
    reg_read(dma_cfg_pkg::RegDoneId, value);
    check("done ID after one job", value, 32'd1);
    compare_memory();
    end_test("single page job", err_mark);

    // Random jobs crossing source, destination or both page ends
    err_mark   = errors;
    done_start = exp_next_id;
    for (int unsigned i = 0; i < 20; i++) begin
      src = AW'(rand_bits(4) << 4) |
            ((i % 3 != 1) ? AW'(12 + rand_bits(2)) : AW'(rand_bits(4)));
      dst = 16'h0200 | AW'(rand_bits(4) << 4) |
            ((i % 3 != 0) ? AW'(12 + rand_bits(2)) : AW'(rand_bits(4)));
      len = 16'd5 + 16'(rand_bits(6) % 36);
      launch(src, dst, len);
      wait_done(exp_next_id);
    end
    reg_read(dma_cfg_pkg::RegDoneId, value);
    check("done ID after random jobs", value, 32'(done_start + IW'(20)));
    compare_memory();
    end_test("twenty page crossing jobs", err_mark);

    // Zero length is rejected and moves nothing
    err_mark      = errors;
    writes_before = write_count;
    launch(16'h0010, 16'h0250, 16'd0);
    repeat (20) @(negedge clk);
    reg_read(dma_cfg_pkg::RegNextId, value);
    check("next ID after zero length", value, 32'(exp_next_id));
    check("memory writes after zero length", write_count, writes_before);
    end_test("zero length rejected", err_mark);

    // Source runs into the error region
    err_mark = errors;
    launch(16'h02f8, 16'h0380, 16'd24);
    wait_done(exp_next_id);
    reg_read(dma_cfg_pkg::RegStatus, value);
    check("error bit after failed reads", 32'(value[dma_cfg_pkg::StatusErrorBit]), 32'd1);
    compare_memory();
    reg_write(dma_cfg_pkg::RegStatus, '0);
    reg_read(dma_cfg_pkg::RegStatus, value);
    check("error bit after clear", 32'(value[dma_cfg_pkg::StatusErrorBit]), 32'd0);
    end_test("read error and sticky flag", err_mark);

    // Two launches without waiting in between
    err_mark = errors;
    src = AW'(rand_bits(8));
    dst = 16'h0200 | AW'(rand_bits(8));
    launch(src, dst, 16'd1 + 16'(rand_bits(5)));
    src = AW'(rand_bits(8));
    dst = 16'h0200 | AW'(rand_bits(8));
    launch(src, dst, 16'd1 + 16'(rand_bits(5)));
    reg_read(dma_cfg_pkg::RegStatus, value);
    check("busy bit while jobs run", 32'(value[dma_cfg_pkg::StatusBusyBit]), 32'd1);
    wait_done(exp_next_id);
    reg_read(dma_cfg_pkg::RegNextId, value);
    check("next ID after queued jobs", value, 32'(exp_next_id));
    reg_read(dma_cfg_pkg::RegDoneId, value);
    check("done ID after queued jobs", value, 32'(exp_next_id));
    wait_idle();
    reg_read(dma_cfg_pkg::RegStatus, value);
    check("busy bit when idle", 32'(value[dma_cfg_pkg::StatusBusyBit]), 32'd0);
    compare_memory();
    end_test("back to back queued jobs", err_mark);

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* dma_properties.sv */
/*
 * DMA protocol assertions
 * Memory strobes and the job and fragment valid/ready handshakes,
 * bound into the DMA top level
 */
`timescale 1ns/1ps

module dma_properties (
  input logic                     clk_i,
  input logic                     arst_n_i,
  input logic                     mem_req_i,
  input logic                     mem_we_i,
  input logic                     job_valid_i,
  input logic                     job_ready_i,
  input dma_types_pkg::dma_job_t  job_data_i,
  input logic                     frag_valid_i,
  input logic                     frag_ready_i,
  input dma_types_pkg::dma_frag_t frag_data_i
);

  // A write is always a request with the write strobe set
  write_needs_req: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) mem_we_i |-> mem_req_i
  ) else $error("memory write strobe without request");

  job_hold: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    job_valid_i && !job_ready_i |=> job_valid_i && $stable(job_data_i)
  ) else $error("job dropped or changed before it was taken");

  frag_hold: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    frag_valid_i && !frag_ready_i |=> frag_valid_i && $stable(frag_data_i)
  ) else $error("fragment dropped or changed before it was taken");

  // Memory stays quiet while reset is held
  quiet_in_reset: assert property (
    @(posedge clk_i) !arst_n_i |-> !mem_req_i
  ) else $error("memory request during reset");

endmodule

bind dma_top dma_properties i_dma_properties (
  .clk_i        ( clk_i           ),
  .arst_n_i     ( arst_n_i        ),
  .mem_req_i    ( mem_req_o       ),
  .mem_we_i     ( mem_we_o        ),
  .job_valid_i  ( i_job_if.valid  ),
  .job_ready_i  ( i_job_if.ready  ),
  .job_data_i   ( i_job_if.data   ),
  .frag_valid_i ( i_frag_if.valid ),
  .frag_ready_i ( i_frag_if.ready ),
  .frag_data_i  ( i_frag_if.data  )
);

/* dma_top.sv */
/*
 * Copy DMA top level
 * Register frontend, page splitter, copy engine and completion stage
 */
`timescale 1ns/1ps

module dma_top #(
  parameter int unsigned JobFifoDepth  = dma_cfg_pkg::JobFifoDepthDefault,
  parameter int unsigned PageWordsLog2 = dma_cfg_pkg::PageWordsLog2Default
) (
  input  logic                                 clk_i,
  input  logic                                 arst_n_i,
  input  logic                                 reg_we_i,
  input  logic                                 reg_re_i,
  input  logic [dma_cfg_pkg::RegAddrWidth-1:0] reg_addr_i,
  input  logic [dma_cfg_pkg::DataWidth-1:0]    reg_wdata_i,
  output logic [dma_cfg_pkg::DataWidth-1:0]    reg_rdata_o,
  output logic                                 mem_req_o,
  output logic                                 mem_we_o,
  output logic [dma_cfg_pkg::AddrWidth-1:0]    mem_addr_o,
  output logic [dma_cfg_pkg::DataWidth-1:0]    mem_wdata_o,
  input  logic [dma_cfg_pkg::DataWidth-1:0]    mem_rdata_i,
  input  logic                                 mem_err_i
);

  logic [dma_cfg_pkg::IdWidth-1:0] done_id;
  logic                            error;
  logic                            error_clear;
  logic                            splitter_busy;

  job_if  i_job_if ();
  frag_if i_frag_if ();

  dma_reg_decode #(
    .JobFifoDepth ( JobFifoDepth )
  ) i_reg_decode (
    .clk_i,
    .arst_n_i,
    .reg_we_i,
    .reg_re_i,
    .reg_addr_i,
    .reg_wdata_i,
    .reg_rdata_o,
    .done_id_i     ( done_id       ),
    .error_i       ( error         ),
    .engine_busy_i ( splitter_busy ),
    .error_clear_o ( error_clear   ),
    .job           ( i_job_if      )
  );

  dma_page_splitter #(
    .PageWordsLog2 ( PageWordsLog2 )
  ) i_page_splitter (
    .clk_i,
    .arst_n_i,
    .job    ( i_job_if      ),
    .frag   ( i_frag_if     ),
    .busy_o ( splitter_busy )
  );

  dma_copy_engine i_copy_engine (
    .clk_i,
    .arst_n_i,
    .frag ( i_frag_if ),
    .mem_req_o,
    .mem_we_o,
    .mem_addr_o,
    .mem_wdata_o,
    .mem_rdata_i,
    .mem_err_i
  );

  dma_completion i_completion (
    .clk_i,
    .arst_n_i,
    .frag          ( i_frag_if   ),
    .error_clear_i ( error_clear ),
    .done_id_o     ( done_id     ),
    .error_o       ( error       )
  );

endmodule

/* dma_completion.sv */
/*
 * DMA completion stage
 * Counts finished jobs and keeps a sticky error from fragment responses
 */
`timescale 1ns/1ps

module dma_completion (
  input  logic                            clk_i,
  input  logic                            arst_n_i,
  frag_if.monitor                         frag,
  input  logic                            error_clear_i,
  output logic [dma_cfg_pkg::IdWidth-1:0] done_id_o,
  output logic                            error_o
);

  logic [dma_cfg_pkg::IdWidth-1:0] done_id_q;
  logic                            error_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      done_id_q <= '0;
      error_q   <= 1'b0;
    end else begin
      // Only the last fragment retires a job
      if (frag.rsp_valid && frag.rsp.last) begin
        done_id_q <= done_id_q + 1'b1;
      end
      // A new error wins over a clear in the same cycle
      if (frag.rsp_valid && frag.rsp.error) begin
        error_q <= 1'b1;
      end else if (error_clear_i) begin
        error_q <= 1'b0;
      end
    end
  end

  assign done_id_o = done_id_q;
  assign error_o   = error_q;

endmodule

/* dma_copy_engine.sv */
/*
 * DMA copy engine
 * Moves one fragment word by word, read then write, and returns one
 * response per fragment
 */
`timescale 1ns/1ps

module dma_copy_engine (
  input  logic                              clk_i,
  input  logic                              arst_n_i,
  frag_if.engine                            frag,
  output logic                              mem_req_o,
  output logic                              mem_we_o,
  output logic [dma_cfg_pkg::AddrWidth-1:0] mem_addr_o,
  output logic [dma_cfg_pkg::DataWidth-1:0] mem_wdata_o,
  input  logic [dma_cfg_pkg::DataWidth-1:0] mem_rdata_i,
  input  logic                              mem_err_i
);

  localparam int unsigned AddrWidth = dma_cfg_pkg::AddrWidth;
  localparam int unsigned LenWidth  = dma_cfg_pkg::LenWidth;

  logic                    busy_q;
  logic                    write_q;
  logic                    rsp_valid_q;
  logic [AddrWidth-1:0]    src_q;
  logic [AddrWidth-1:0]    dst_q;
  logic [LenWidth-1:0]     cnt_q;
  logic                    last_q;
  logic                    err_q;
  dma_types_pkg::dma_rsp_t rsp_q;
  logic                    take;
  logic                    word_done;
  logic                    frag_done;

  assign frag.ready = !busy_q;
  assign take       = frag.valid && !busy_q;
  assign word_done  = busy_q && write_q;
  assign frag_done  = word_done && (cnt_q == LenWidth'(1));

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q      <= 1'b0;
      write_q     <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= frag_done;
      if (take) begin
        busy_q  <= 1'b1;
        write_q <= 1'b0;
      end else if (busy_q) begin
        write_q <= !write_q;
        if (frag_done) begin
          busy_q <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      src_q  <= frag.data.src.flat;
      dst_q  <= frag.data.dst.flat;
      cnt_q  <= frag.data.len;
      last_q <= frag.data.last;
      err_q  <= 1'b0;
    end else if (word_done) begin
      src_q <= src_q + 1'b1;
      dst_q <= dst_q + 1'b1;
      cnt_q <= cnt_q - 1'b1;
      err_q <= err_q | mem_err_i;
    end
    if (frag_done) begin
      rsp_q.error <= err_q | mem_err_i;
      rsp_q.last  <= last_q;
    end
  end

  // A failed read drops the matching write and the walk goes on
  assign mem_req_o   = busy_q && !(write_q && mem_err_i);
  assign mem_we_o    = busy_q && write_q && !mem_err_i;
  assign mem_addr_o  = write_q ? dst_q : src_q;
  assign mem_wdata_o = mem_rdata_i;

  assign frag.rsp_valid = rsp_valid_q;
  assign frag.rsp       = rsp_q;

endmodule

/* dma_page_splitter.sv */
/*
 * DMA page splitter
 * Cuts each job into fragments that stay inside one page on both sides
 */
`timescale 1ns/1ps

module dma_page_splitter #(
  parameter int unsigned PageWordsLog2 = dma_cfg_pkg::PageWordsLog2Default
) (
  input  logic   clk_i,
  input  logic   arst_n_i,
  job_if.sink    job,
  frag_if.source frag,
  output logic   busy_o
);

  localparam int unsigned AddrWidth = dma_cfg_pkg::AddrWidth;
  localparam int unsigned LenWidth  = dma_cfg_pkg::LenWidth;
  localparam logic [LenWidth-1:0] PageWords = LenWidth'(1) << PageWordsLog2;

  dma_types_pkg::dma_addr_u src_q;
  dma_types_pkg::dma_addr_u dst_q;
  logic [LenWidth-1:0]      rem_q;
  logic [LenWidth-1:0]      src_room;
  logic [LenWidth-1:0]      dst_room;
  logic [LenWidth-1:0]      frag_len;
  logic                     frag_last;
  logic                     active_q;
  logic                     inflight_q;
  logic                     job_take;
  logic                     frag_take;

  // Words left up to the end of the current page on each side
  assign src_room = PageWords - LenWidth'(src_q.paged.offset);
  assign dst_room = PageWords - LenWidth'(dst_q.paged.offset);

  always_comb begin
    frag_len = rem_q;
    if (src_room < frag_len) begin
      frag_len = src_room;
    end
    if (dst_room < frag_len) begin
      frag_len = dst_room;
    end
  end

  assign frag_last = (frag_len == rem_q);

  // A new job is taken only once the previous one is fully cut
  assign job.ready = !active_q;
  assign job_take  = job.valid && !active_q;

  assign frag.valid = active_q;
  assign frag.data  = '{src: src_q, dst: dst_q, len: frag_len, last: frag_last};
  assign frag_take  = frag.valid && frag.ready;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      active_q   <= 1'b0;
      inflight_q <= 1'b0;
    end else begin
      if (job_take) begin
        active_q <= 1'b1;
      end else if (frag_take && frag_last) begin
        active_q <= 1'b0;
      end
      if (frag_take) begin
        inflight_q <= 1'b1;
      end else if (frag.rsp_valid) begin
        inflight_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (job_take) begin
      src_q <= job.data.src;
      dst_q <= job.data.dst;
      rem_q <= job.data.len;
    end else if (frag_take) begin
      src_q.flat <= src_q.flat + AddrWidth'(frag_len);
      dst_q.flat <= dst_q.flat + AddrWidth'(frag_len);
      rem_q      <= rem_q - frag_len;
    end
  end

  assign busy_o = active_q || inflight_q;

endmodule

/* dma_reg_decode.sv */
/*
 * DMA register frontend
 * Decodes register accesses, launches jobs with a fresh ID on a length
 * write and keeps accepted jobs in a small circular queue
 */
`timescale 1ns/1ps

module dma_reg_decode #(
  parameter int unsigned JobFifoDepth = dma_cfg_pkg::JobFifoDepthDefault
) (
  input  logic                                 clk_i,
  input  logic                                 arst_n_i,
  input  logic                                 reg_we_i,
  input  logic                                 reg_re_i,
  input  logic [dma_cfg_pkg::RegAddrWidth-1:0] reg_addr_i,
  input  logic [dma_cfg_pkg::DataWidth-1:0]    reg_wdata_i,
  output logic [dma_cfg_pkg::DataWidth-1:0]    reg_rdata_o,
  input  logic [dma_cfg_pkg::IdWidth-1:0]      done_id_i,
  input  logic                                 error_i,
  input  logic                                 engine_busy_i,
  output logic                                 error_clear_o,
  job_if.source                                job
);

  localparam int unsigned AddrWidth = dma_cfg_pkg::AddrWidth;
  localparam int unsigned DataWidth = dma_cfg_pkg::DataWidth;
  localparam int unsigned LenWidth  = dma_cfg_pkg::LenWidth;
  localparam int unsigned PtrWidth  = (JobFifoDepth > 1) ? $clog2(JobFifoDepth) : 1;
  localparam int unsigned CntWidth  = $clog2(JobFifoDepth + 1);

  logic [AddrWidth-1:0]            src_q;
  logic [AddrWidth-1:0]            dst_q;
  logic [dma_cfg_pkg::IdWidth-1:0] next_id_q;
  logic [DataWidth-1:0]            rdata_q;
  logic [DataWidth-1:0]            status;
  logic [LenWidth-1:0]             wr_len;
  dma_types_pkg::dma_job_t         queue_q [JobFifoDepth];
  dma_types_pkg::dma_job_t         push_job;
  logic [PtrWidth-1:0]             wr_ptr_q;
  logic [PtrWidth-1:0]             rd_ptr_q;
  logic [CntWidth-1:0]             count_q;
  logic                            full;
  logic                            launch;
  logic                            pop;

  // Wraps at the queue depth, which need not be a power of two
  function automatic logic [PtrWidth-1:0] ptr_next(input logic [PtrWidth-1:0] ptr);
    if (ptr == PtrWidth'(JobFifoDepth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign wr_len = reg_wdata_i[LenWidth-1:0];
  assign full   = (count_q == CntWidth'(JobFifoDepth));

  // Zero lengths and writes into a full queue are dropped
  assign launch = reg_we_i && (reg_addr_i == dma_cfg_pkg::RegLen) && (wr_len != '0) && !full;
  assign pop    = job.valid && job.ready;

  assign error_clear_o = reg_we_i && (reg_addr_i == dma_cfg_pkg::RegStatus);

  always_comb begin
    status = '0;
    status[dma_cfg_pkg::StatusBusyBit]  = (count_q != '0) || engine_busy_i;
    status[dma_cfg_pkg::StatusErrorBit] = error_i;
  end

  always_comb begin
    push_job          = '0;
    push_job.src.flat = src_q;
    push_job.dst.flat = dst_q;
    push_job.len      = wr_len;
    push_job.id       = next_id_q;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      src_q <= '0;
      dst_q <= '0;
    end else if (reg_we_i) begin
      if (reg_addr_i == dma_cfg_pkg::RegSrc) begin
        src_q <= reg_wdata_i[AddrWidth-1:0];
      end
      if (reg_addr_i == dma_cfg_pkg::RegDst) begin
        dst_q <= reg_wdata_i[AddrWidth-1:0];
      end
    end
  end

  // Queue pointers and ID issue
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
      count_q   <= '0;
      next_id_q <= '0;
    end else begin
      if (launch) begin
        wr_ptr_q  <= ptr_next(wr_ptr_q);
        next_id_q <= next_id_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      if (launch && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !launch) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (launch) begin
      queue_q[wr_ptr_q] <= push_job;
    end
  end

  assign job.valid = (count_q != '0);
  assign job.data  = queue_q[rd_ptr_q];

  // Read data shows up one cycle after the strobe
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rdata_q <= '0;
    end else if (reg_re_i) begin
      case (reg_addr_i)
        dma_cfg_pkg::RegSrc:    rdata_q <= DataWidth'(src_q);
        dma_cfg_pkg::RegDst:    rdata_q <= DataWidth'(dst_q);
        dma_cfg_pkg::RegStatus: rdata_q <= status;
        dma_cfg_pkg::RegDoneId: rdata_q <= DataWidth'(done_id_i);
        dma_cfg_pkg::RegNextId: rdata_q <= DataWidth'(next_id_q);
        default:                rdata_q <= '0;
      endcase
    end
  end

  assign reg_rdata_o = rdata_q;

endmodule

/* dma_ifs.sv */
/*
 * DMA stage interfaces
 * job_if carries jobs from the register stage to the splitter,
 * frag_if carries fragments to the copy engine and its responses back
 */
`timescale 1ns/1ps

interface job_if;

  logic                    valid;
  logic                    ready;
  dma_types_pkg::dma_job_t data;

  modport source (
    output valid,
    output data,
    input  ready
  );

  modport sink (
    input  valid,
    input  data,
    output ready
  );

endinterface

interface frag_if;

  logic                     valid;
  logic                     ready;
  dma_types_pkg::dma_frag_t data;

  // Response path carries one pulse per fragment and is always accepted
  logic                     rsp_valid;
  dma_types_pkg::dma_rsp_t  rsp;

  modport source (
    output valid,
    output data,
    input  ready,
    input  rsp_valid
  );

  modport engine (
    input  valid,
    input  data,
    output ready,
    output rsp_valid,
    output rsp
  );

  modport monitor (
    input rsp_valid,
    input rsp
  );

endinterface

/* dma_types_pkg.sv */
/*
 * DMA data records
 * Address word with its paged view, job, fragment and response
 */
package dma_types_pkg;

  localparam int unsigned OffsetWidth  = dma_cfg_pkg::PageWordsLog2Default;
  localparam int unsigned PageNumWidth = dma_cfg_pkg::AddrWidth - OffsetWidth;

  // One address word, seen flat or split at the page boundary
  typedef union packed {
    logic [dma_cfg_pkg::AddrWidth-1:0] flat;
    struct packed {
      logic [PageNumWidth-1:0] page;
      logic [OffsetWidth-1:0]  offset;
    } paged;
  } dma_addr_u;

  // Job as launched by software
  typedef struct packed {
    dma_addr_u                        src;
    dma_addr_u                        dst;
    logic [dma_cfg_pkg::LenWidth-1:0] len;
    logic [dma_cfg_pkg::IdWidth-1:0]  id;
  } dma_job_t;

  // Fragment that stays inside one page on both sides
  typedef struct packed {
    dma_addr_u                        src;
    dma_addr_u                        dst;
    logic [dma_cfg_pkg::LenWidth-1:0] len;
    logic                             last;
  } dma_frag_t;

  typedef struct packed {
    logic error;
    logic last;
  } dma_rsp_t;

endpackage

/* dma_cfg_pkg.sv */
/*
 * DMA configuration constants
 * Word widths, default page and queue sizes and the register map
 */
package dma_cfg_pkg;

  // Datapath widths
  localparam int unsigned AddrWidth = 16;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned LenWidth  = 16;
  localparam int unsigned IdWidth   = 8;

  // Defaults for the top level parameters
  localparam int unsigned PageWordsLog2Default = 4;
  localparam int unsigned JobFifoDepthDefault  = 2;

  // Register map with one word per offset
  localparam int unsigned RegAddrWidth = 3;
  localparam logic [RegAddrWidth-1:0] RegSrc    = 3'd0;
  localparam logic [RegAddrWidth-1:0] RegDst    = 3'd1;
  localparam logic [RegAddrWidth-1:0] RegLen    = 3'd2;
  localparam logic [RegAddrWidth-1:0] RegStatus = 3'd3;
  localparam logic [RegAddrWidth-1:0] RegDoneId = 3'd4;
  localparam logic [RegAddrWidth-1:0] RegNextId = 3'd5;

  // Status word layout
  localparam int unsigned StatusBusyBit  = 0;
  localparam int unsigned StatusErrorBit = 1;

endpackage
